/* logic/icache_pkg.sv */
// instruction cache geometry
package icache_pkg;

    ////////////////////
    // address layout

    localparam int addr_w  = 30;    // word address
    localparam int index_w = 8;     // set index, address bits 9..2
    localparam int tag_w   = 20;    // address bits 29..10
    localparam int sets    = 256;   // one entry per index value

    ////////////////////
    // line layout

    localparam int line_w = 128;    // four words per line
    localparam int word_w = 32;

    typedef logic [line_w-1:0] line_t;

    ////////////////////
    // controller states

    // ic_idle       waits for a fetch, starts the array read
    // ic_lookup     combines way hits, answers or decides a miss
    // ic_wait_grant L2 bus busy, request held
    // ic_refill     waits for the line of the right thread
    // ic_write      victim way takes the new line
    typedef enum logic [2:0] {
        ic_idle,
        ic_lookup,
        ic_wait_grant,
        ic_refill,
        ic_write
    } ic_state_t;

endpackage

/* logic/l2_pkg.sv */
// L2 refill side definitions
package l2_pkg;

    ////////////////////
    // thread ids

    localparam int thread_w = 2;    // four hardware threads

    typedef logic [thread_w-1:0] thread_t;

    ////////////////////
    // refill line

    // the L2 always returns a whole line
    localparam int words_per_line = 4;
    localparam int word_sel_w     = $clog2(words_per_line);    // word offset bits

endpackage

/* logic/icache_way_if.sv */
// cache way to controller link
`timescale 1ns/1ps

interface icache_way_if;

    // lookup and write control, from the controller
    logic                           rd_en;      // read the set at index
    logic [icache_pkg::index_w-1:0] index;
    logic [icache_pkg::tag_w-1:0]   rd_tag;     // compare tag, also the write tag
    l2_pkg::thread_t                thread;     // compare thread, also the write thread
    logic                           wr_en;      // write the whole entry
    icache_pkg::line_t              wr_line;

    // read results, from the way
    logic                           valid;      // registered valid bit
    logic                           hit;
    icache_pkg::line_t              rd_line;

    modport way (
        input  rd_en, index, rd_tag, thread, wr_en, wr_line,
        output valid, hit, rd_line
    );

    modport ctrl (
        output rd_en, index, rd_tag, thread, wr_en, wr_line,
        input  valid, hit, rd_line
    );

endinterface

/* logic/icache_way.sv */
// one cache way
`timescale 1ns/1ps

module icache_way (
    input logic       clk,
    input logic       rst_n,
    icache_way_if.way bus
);

    ////////////////////
    // storage

    logic [icache_pkg::tag_w-1:0] tag_mem [icache_pkg::sets];
    l2_pkg::thread_t              thread_mem [icache_pkg::sets];
    icache_pkg::line_t            data_mem [icache_pkg::sets];
    logic [icache_pkg::sets-1:0]  valid_bits;    // cleared by reset

    logic [icache_pkg::tag_w-1:0] tag_q;         // registered entry
    l2_pkg::thread_t              thread_q;
    logic                         valid_q;

    // array write, whole entry at once
    always_ff @(posedge clk) begin
        if (bus.wr_en) begin
            tag_mem[bus.index]    <= bus.rd_tag;
            thread_mem[bus.index] <= bus.thread;
            data_mem[bus.index]   <= bus.wr_line;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;
        end else if (bus.wr_en) begin
            valid_bits[bus.index] <= 1'b1;
        end
    end

    ////////////////////
    // read port

    // one cycle latency, outputs hold until the next read
    always_ff @(posedge clk) begin
        if (bus.rd_en) begin
            tag_q       <= tag_mem[bus.index];
            thread_q    <= thread_mem[bus.index];
            bus.rd_line <= data_mem[bus.index];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (bus.rd_en) begin
            valid_q <= valid_bits[bus.index];
        end
    end

    ////////////////////
    // compare

    assign bus.valid = valid_q;
    // a line from another thread never hits
    assign bus.hit   = valid_q && (tag_q == bus.rd_tag) && (thread_q == bus.thread);

endmodule

/* logic/icache_ctrl.sv */
// instruction cache controller
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    // cpu side
    input  logic                          fetch_req,
    input  logic [icache_pkg::addr_w-1:0] fetch_addr,
    input  l2_pkg::thread_t               fetch_thread,
    output logic [icache_pkg::word_w-1:0] cpu_data,
    output logic                          data_rdy,
    output logic                          miss_stall,
    // l2 side
    output logic                          l2_req,
    input  logic                          l2_grant,
    input  logic                          l2_rdy,
    input  l2_pkg::thread_t               l2_thread,
    input  icache_pkg::line_t             l2_line,
    // way blocks
    icache_way_if.ctrl                    way0,
    icache_way_if.ctrl                    way1
);

    icache_pkg::ic_state_t           state, next_state;
    logic [icache_pkg::addr_w-1:0]   req_addr;        // held request
    l2_pkg::thread_t                 req_thread;
    logic [icache_pkg::index_w-1:0]  req_index, fetch_index;
    logic [icache_pkg::tag_w-1:0]    req_tag;
    logic [l2_pkg::word_sel_w-1:0]   req_word;
    icache_pkg::line_t               fill_line;       // line kept for ic_write
    icache_pkg::line_t               hit_line;
    logic [icache_pkg::sets-1:0]     lru_bits;        // 1 = way 1 is next victim
    logic                            victim, victim_pick;
    logic                            take_req, any_hit, lookup_miss, refill_done;

    function automatic logic [icache_pkg::word_w-1:0] select_word(
        input icache_pkg::line_t             line,
        input logic [l2_pkg::word_sel_w-1:0] sel
    );
        return line[sel*icache_pkg::word_w +: icache_pkg::word_w];
    endfunction

    ////////////////////
    // request decode

    assign take_req    = (state == icache_pkg::ic_idle) && fetch_req;
    assign fetch_index = fetch_addr[l2_pkg::word_sel_w +: icache_pkg::index_w];
    assign req_index   = req_addr[l2_pkg::word_sel_w +: icache_pkg::index_w];
    assign req_tag     = req_addr[icache_pkg::addr_w-1 -: icache_pkg::tag_w];
    assign req_word    = req_addr[l2_pkg::word_sel_w-1:0];

    always_ff @(posedge clk) begin
        if (take_req) begin
            req_addr   <= fetch_addr;
            req_thread <= fetch_thread;
        end
    end

    // way 0 wins when both hit
    assign any_hit     = way0.hit || way1.hit;
    assign hit_line    = way0.hit ? way0.rd_line : way1.rd_line;
    assign lookup_miss = (state == icache_pkg::ic_lookup) && !any_hit;
    assign refill_done = l2_rdy && (l2_thread == req_thread);    // other threads ignored

    // invalid ways first, then the lru way
    assign victim_pick = !way0.valid ? 1'b0 : (!way1.valid ? 1'b1 : lru_bits[req_index]);

    ////////////////////
    // state machine

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= icache_pkg::ic_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            icache_pkg::ic_idle: begin
                if (fetch_req) next_state = icache_pkg::ic_lookup;
            end
            icache_pkg::ic_lookup: begin
                if (any_hit) begin
                    next_state = icache_pkg::ic_idle;
                end else if (l2_grant) begin
                    next_state = icache_pkg::ic_refill;
                end else begin
                    next_state = icache_pkg::ic_wait_grant;
                end
            end
            icache_pkg::ic_wait_grant: begin
                if (l2_grant) next_state = icache_pkg::ic_refill;
            end
            icache_pkg::ic_refill: begin
                if (refill_done) next_state = icache_pkg::ic_write;
            end
            icache_pkg::ic_write: next_state = icache_pkg::ic_idle;
            default:              next_state = icache_pkg::ic_idle;
        endcase
    end

    ////////////////////
    // cpu and l2 outputs

    assign data_rdy   = (state == icache_pkg::ic_lookup && any_hit) ||
                        (state == icache_pkg::ic_refill && refill_done);
    assign miss_stall = lookup_miss || (state == icache_pkg::ic_wait_grant) ||
                        (state == icache_pkg::ic_refill && !refill_done);
    assign l2_req     = lookup_miss || (state == icache_pkg::ic_wait_grant) ||
                        (state == icache_pkg::ic_refill);

    always_comb begin
        cpu_data = '0;
        if (state == icache_pkg::ic_lookup) begin
            cpu_data = select_word(hit_line, req_word);
        end else if (state == icache_pkg::ic_refill) begin
            cpu_data = select_word(l2_line, req_word);    // straight from the bus
        end
    end

    always_ff @(posedge clk) begin
        if (state == icache_pkg::ic_refill && refill_done) begin
            fill_line <= l2_line;
        end
    end

    ////////////////////
    // replacement

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim <= 1'b0;
        end else if (lookup_miss) begin
            victim <= victim_pick;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_bits <= '0;
        end else if (state == icache_pkg::ic_lookup && any_hit) begin
            lru_bits[req_index] <= way0.hit;    // point at the other way
        end else if (state == icache_pkg::ic_write) begin
            lru_bits[req_index] <= !victim;
        end
    end

    ////////////////////
    // way control

    assign way0.rd_en   = take_req;
    assign way1.rd_en   = take_req;
    assign way0.index   = (state == icache_pkg::ic_idle) ? fetch_index : req_index;
    assign way1.index   = (state == icache_pkg::ic_idle) ? fetch_index : req_index;
    assign way0.rd_tag  = req_tag;
    assign way1.rd_tag  = req_tag;
    assign way0.thread  = req_thread;
    assign way1.thread  = req_thread;
    assign way0.wr_en   = (state == icache_pkg::ic_write) && !victim;
    assign way1.wr_en   = (state == icache_pkg::ic_write) && victim;
    assign way0.wr_line = fill_line;
    assign way1.wr_line = fill_line;

endmodule

/* logic/icache_top.sv */
// two way instruction cache
`timescale 1ns/1ps

module icache_top (
    input  logic                          clk,
    input  logic                          rst_n,
    // cpu fetch port
    input  logic                          fetch_req,
    input  logic [icache_pkg::addr_w-1:0] fetch_addr,
    input  l2_pkg::thread_t               fetch_thread,
    output logic [icache_pkg::word_w-1:0] cpu_data,
    output logic                          data_rdy,      // one cycle strobe
    output logic                          miss_stall,
    // l2 refill port
    output logic                          l2_req,
    input  logic                          l2_grant,      // bus free for this cache
    input  logic                          l2_rdy,
    input  l2_pkg::thread_t               l2_thread,
    input  icache_pkg::line_t             l2_line
);

    ////////////////////
    // way links

    icache_way_if way0_bus ();
    icache_way_if way1_bus ();

    icache_way u_way0 (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (way0_bus)
    );

    icache_way u_way1 (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (way1_bus)
    );

    ////////////////////
    // controller

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_thread (fetch_thread),
        .cpu_data     (cpu_data),
        .data_rdy     (data_rdy),
        .miss_stall   (miss_stall),
        .l2_req       (l2_req),
        .l2_grant     (l2_grant),
        .l2_rdy       (l2_rdy),
        .l2_thread    (l2_thread),
        .l2_line      (l2_line),
        .way0         (way0_bus),
        .way1         (way1_bus)
    );

endmodule

/* sim/tb_clock.sv */
// testbench clock source
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    localparam int half_period = 10;    // 20 ns period

    initial begin
        clk = 1'b0;
        forever begin
            #(half_period) clk = ~clk;
        end
    end

endmodule

/* sim/icache_properties.sv */
// icache controller assertions
`timescale 1ns/1ps

module icache_properties (
    input logic                  clk,
    input logic                  rst_n,
    input icache_pkg::ic_state_t state,
    input logic                  data_rdy,
    input logic                  miss_stall,
    input logic                  l2_req,
    input logic                  wr_en0,
    input logic                  wr_en1
);

    int fail_count = 0;    // failed assertions so far

    ////////////////////
    // cpu side

    data_rdy_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        data_rdy |=> !data_rdy)
        else begin
            fail_count++;
            $error("data_rdy stayed high for more than one cycle");
        end

    stall_excludes_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        !(miss_stall && data_rdy))
        else begin
            fail_count++;
            $error("miss_stall and data_rdy high in the same cycle");
        end

    ////////////////////
    // l2 and arrays

    no_req_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == icache_pkg::ic_idle) |-> !l2_req)
        else begin
            fail_count++;
            $error("l2_req high while the controller is idle");
        end

    write_only_in_write: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_en0 || wr_en1) |-> (state == icache_pkg::ic_write))
        else begin
            fail_count++;
            $error("way write enable outside ic_write");
        end

endmodule

bind icache_ctrl icache_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .state      (state),
    .data_rdy   (data_rdy),
    .miss_stall (miss_stall),
    .l2_req     (l2_req),
    .wr_en0     (way0.wr_en),
    .wr_en1     (way1.wr_en)
);

/* sim/icache_tb.sv */
// icache testbench
`timescale 1ns/1ps

module icache_tb;

    localparam int     seed           = 36;
    localparam int     test_count     = 200;
    localparam int     directed_count = 8;
    localparam int     cycles_per_req = 24;    // miss with every delay at its longest
    localparam longint watchdog_ns    =
        longint'(test_count + directed_count) * cycles_per_req * 20 + 16 * 20 + 200;

    logic                          clk;
    logic                          rst_n;
    logic                          fetch_req;
    logic [icache_pkg::addr_w-1:0] fetch_addr;
    l2_pkg::thread_t               fetch_thread;
    logic [icache_pkg::word_w-1:0] cpu_data;
    logic                          data_rdy;
    logic                          miss_stall;
    logic                          l2_req;
    logic                          l2_grant;
    logic                          l2_rdy;
    l2_pkg::thread_t               l2_thread;
    icache_pkg::line_t             l2_line;

    logic [15:0] lfsr;
    int          errors;

    // cache model, per way and set
    logic                         m_valid  [2][icache_pkg::sets];
    logic [icache_pkg::tag_w-1:0] m_tag    [2][icache_pkg::sets];
    l2_pkg::thread_t              m_thread [2][icache_pkg::sets];
    logic                         m_lru    [icache_pkg::sets];    // 1 = way 1 goes next

    tb_clock u_clock (.clk(clk));

    icache_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_thread (fetch_thread),
        .cpu_data     (cpu_data),
        .data_rdy     (data_rdy),
        .miss_stall   (miss_stall),
        .l2_req       (l2_req),
        .l2_grant     (l2_grant),
        .l2_rdy       (l2_rdy),
        .l2_thread    (l2_thread),
        .l2_line      (l2_line)
    );

    ////////////////////
    // helpers

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // L2 content, fixed per line address and word position
    function automatic logic [31:0] line_word(input logic [27:0] line_addr,
                                              input logic [1:0]  pos);
        return {pos, ~pos, line_addr} ^ {line_addr[11:0], 20'h0};
    endfunction

    function automatic icache_pkg::line_t make_line(input logic [27:0] line_addr);
        icache_pkg::line_t line;
        for (int p = 0; p < 4; p++) begin
            line[p*32 +: 32] = line_word(line_addr, p[1:0]);
        end
        return line;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_stalled();
        check_value("l2_req", 32'(l2_req), 32'd1);
        check_value("miss_stall", 32'(miss_stall), 32'd1);
        check_value("data_rdy", 32'(data_rdy), 32'd0);
    endtask

    ////////////////////
    // cache model

    task automatic model_lookup(input logic [29:0] addr, input l2_pkg::thread_t thr,
                                output logic hit, output logic way);
        logic [7:0]  idx;
        logic [19:0] tag;
        idx = addr[9:2];
        tag = addr[29:10];
        hit = 1'b0;
        way = 1'b0;
        for (int w = 1; w >= 0; w--) begin    // way 0 last, so it wins
            if (m_valid[w][idx] && m_tag[w][idx] == tag && m_thread[w][idx] == thr) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (!hit) begin
            way = !m_valid[0][idx] ? 1'b0 : (!m_valid[1][idx] ? 1'b1 : m_lru[idx]);
        end
    endtask

    task automatic model_update(input logic [29:0] addr, input l2_pkg::thread_t thr,
                                input logic hit, input logic way);
        if (!hit) begin
            m_valid[way][addr[9:2]]  = 1'b1;
            m_tag[way][addr[9:2]]    = addr[29:10];
            m_thread[way][addr[9:2]] = thr;
        end
        m_lru[addr[9:2]] = !way;    // other way goes next
    endtask

    ////////////////////
    // one fetch, with the L2 side on a miss

    task automatic fetch(input logic [29:0] addr, input l2_pkg::thread_t thr);
        logic        hit;
        logic        way;
        logic        early;
        int          wait_cycles;
        int          rdy_cycles;
        logic [31:0] exp_word;
        model_lookup(addr, thr, hit, way);
        exp_word = line_word(addr[29:2], addr[1:0]);
        early    = (rand_bits(1) != 0);    // grant already free at the miss
        @(posedge clk);
        #2;
        fetch_req    = 1'b1;
        fetch_addr   = addr;
        fetch_thread = thr;
        l2_grant     = early;
        @(posedge clk);                    // taken in ic_idle
        @(negedge clk);
        check_value("data_rdy", 32'(data_rdy), 32'(hit));
        check_value("l2_req", 32'(l2_req), 32'(!hit));
        check_value("miss_stall", 32'(miss_stall), 32'(!hit));
        if (hit) begin
            check_value("cpu_data", cpu_data, exp_word);
        end else begin
            wait_cycles = early ? 0 : int'(rand_bits(3)) + 1;
            for (int c = 0; c < wait_cycles; c++) begin
                @(posedge clk);
                #2;
                l2_grant = (c == wait_cycles - 1);
                @(negedge clk);
                check_stalled();
            end
            if (rand_bits(1) != 0) begin
                // line for another thread, must be ignored
                @(posedge clk);
                #2;
                l2_rdy    = 1'b1;
                l2_thread = thr + 2'd1;
                l2_line   = make_line(addr[29:2] ^ 28'h1);
                @(negedge clk);
                check_stalled();
            end
            rdy_cycles = int'(rand_bits(2));
            repeat (rdy_cycles) begin
                @(posedge clk);
                #2;
                l2_rdy = 1'b0;
                @(negedge clk);
                check_stalled();
            end
            @(posedge clk);
            #2;
            l2_rdy    = 1'b1;
            l2_thread = thr;
            l2_line   = make_line(addr[29:2]);
            @(negedge clk);
            check_value("data_rdy", 32'(data_rdy), 32'd1);
            check_value("miss_stall", 32'(miss_stall), 32'd0);
            check_value("cpu_data", cpu_data, exp_word);
        end
        @(posedge clk);
        #2;
        fetch_req = 1'b0;
        l2_rdy    = 1'b0;
        l2_grant  = 1'b0;
        @(negedge clk);
        check_value("data_rdy", 32'(data_rdy), 32'd0);
        check_value("l2_req", 32'(l2_req), 32'd0);
        model_update(addr, thr, hit, way);
    endtask

    ////////////////////
    // main sequence

    initial begin
        logic [29:0]     addr;
        l2_pkg::thread_t thr;
        int              total;
        lfsr         = 16'(seed);
        errors       = 0;
        rst_n        = 1'b0;
        fetch_req    = 1'b0;
        fetch_addr   = '0;
        fetch_thread = '0;
        l2_grant     = 1'b0;
        l2_rdy       = 1'b0;
        l2_thread    = '0;
        l2_line      = '0;
        for (int s = 0; s < icache_pkg::sets; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_lru[s]      = 1'b0;
        end
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("data_rdy", 32'(data_rdy), 32'd0);
        check_value("miss_stall", 32'(miss_stall), 32'd0);
        check_value("l2_req", 32'(l2_req), 32'd0);

        // three tags in set 0x40, fills then lru evictions
        fetch({20'd1, 8'h40, 2'd1}, 2'd0);
        fetch({20'd2, 8'h40, 2'd3}, 2'd0);
        fetch({20'd1, 8'h40, 2'd2}, 2'd0);
        fetch({20'd3, 8'h40, 2'd0}, 2'd0);
        fetch({20'd2, 8'h40, 2'd0}, 2'd0);
        fetch({20'd3, 8'h40, 2'd1}, 2'd0);
        // same line, other thread
        fetch({20'd3, 8'h40, 2'd1}, 2'd2);
        fetch({20'd3, 8'h40, 2'd2}, 2'd0);

        for (int n = 0; n < test_count; n++) begin
            addr = {18'd0, 2'(rand_bits(2)), 6'd0, 2'(rand_bits(2)), 2'(rand_bits(2))};
            thr  = 2'(rand_bits(1));
            fetch(addr, thr);
        end

        total = errors + u_dut.u_ctrl.u_props.fail_count;
        $display("%0d check errors, %0d assertion failures", errors,
                 u_dut.u_ctrl.u_props.fail_count);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before all requests completed");
        $display("Errors found");
        $finish;
    end

endmodule

/* sim.f */
logic/icache_pkg.sv
logic/l2_pkg.sv
logic/icache_way_if.sv
logic/icache_way.sv
logic/icache_ctrl.sv
logic/icache_top.sv
sim/tb_clock.sv
sim/icache_properties.sv
sim/icache_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := icache_tb
FILELIST := sim.f
OBJ_DIR  := obj_dir
LOG      := sim.log
RUNOPTS  := +verilator+error+limit+1000

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUNOPTS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
